// File: Bender.yml
package:
  name: soc_dbg

sources:
  - logic/soc_dbg_pkg.sv
  - logic/dbg_regs.sv
  - logic/soc_watchdog.sv
  - logic/rst_ctrl.sv
  - logic/soc_dbg_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_soc_dbg.sv

// File: dv/tb_soc_dbg_tasks.svh
// bus, compare and test tasks
`ifndef TB_SOC_DBG_TASKS_SVH
`define TB_SOC_DBG_TASKS_SVH

  // ******************************
  // apb master and compares
  // ******************************

  // setup cycle, then access held until pready is seen high
  task automatic apb_xfer(input logic wr, input logic [6:0] waddr,
                          input logic [APB_DATA_W-1:0] wdata,
                          output logic [APB_DATA_W-1:0] rdata, output logic err);
    int unsigned n;
    next_cycle();
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = {waddr, 2'b00};
    pwdata_i  = wdata;
    next_cycle();
    penable_i = 1'b1;
    n = 0;
    next_cycle();
    while (pready_o !== 1'b1) begin
      if (n == 16) begin
        abort_run($sformatf("pready never came for word address %h", waddr));
      end
      next_cycle();
      n++;
    end
    rdata = prdata_o;
    err   = pslverr_o;
    // transfer completes on the following edge
    next_cycle();
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic check_word(input logic [APB_DATA_W-1:0] got,
                            input logic [APB_DATA_W-1:0] exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_harts(input logic [NR_HARTS-1:0] got,
                             input logic [NR_HARTS-1:0] exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_cause(input rst_cause_e got, input rst_cause_e exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
      err_cnt++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  // write that must not raise pslverr
  task automatic write_ok(input logic [6:0] waddr, input logic [APB_DATA_W-1:0] wdata);
    logic [APB_DATA_W-1:0] rdata;
    logic                  err;
    apb_xfer(1'b1, waddr, wdata, rdata, err);
    check_bit(err, 1'b0, $sformatf("pslverr on write to %h", waddr));
  endtask

  task automatic read_check(input logic [6:0] waddr, input logic [APB_DATA_W-1:0] exp);
    logic [APB_DATA_W-1:0] rdata;
    logic                  err;
    apb_xfer(1'b0, waddr, '0, rdata, err);
    check_bit(err, 1'b0, $sformatf("pslverr on read of %h", waddr));
    check_word(rdata, exp, $sformatf("word at %h", waddr));
  endtask

  // poll the peripheral reset, bounded
  task automatic wait_rstn(input logic level, input int unsigned limit);
    int unsigned n;
    n = 0;
    while (periph_rstn_o !== level) begin
      if (n == limit) begin
        abort_run($sformatf("periph_rstn_o stuck away from %b for %0d cycles", level, n));
      end
      next_cycle();
      n++;
    end
  endtask

  // ******************************
  // directed tests
  // ******************************

  task automatic test_reset_values();
    int unsigned errs;
    errs = err_cnt;
    wait_rstn(1'b1, 2 * RST_HOLD + 10);
    check_harts(debug_req_o, '0, "debug_req_o after reset");
    check_bit(dmactive_o, 1'b0, "dmactive_o after reset");
    check_cause(rst_cause_o, RST_POWER, "rst_cause_o after reset");
    read_check(ADDR_HARTINFO, HARTINFO_VALUE);
    // hart 0 is selected and present, so only the version shows
    read_check(ADDR_DMSTATUS, 32'h0000_0002);
    end_test("reset values", errs);
  endtask

  task automatic test_scratch_errors();
    int unsigned           errs;
    logic [APB_DATA_W-1:0] d1;
    logic [APB_DATA_W-1:0] rdata;
    logic                  err;
    errs      = err_cnt;
    data0_val = $urandom();
    d1        = $urandom();
    write_ok(ADDR_DATA0, data0_val);
    write_ok(ADDR_DATA1, d1);
    read_check(ADDR_DATA0, data0_val);
    read_check(ADDR_DATA1, d1);
    // word 0x3f lies outside the map
    apb_xfer(1'b0, 7'h3f, '0, rdata, err);
    check_bit(err, 1'b1, "pslverr on unmapped read");
    apb_xfer(1'b1, ADDR_HARTINFO, ~HARTINFO_VALUE, rdata, err);
    check_bit(err, 1'b1, "pslverr on HARTINFO write");
    read_check(ADDR_HARTINFO, HARTINFO_VALUE);
    end_test("scratch and errors", errs);
  endtask

  // active plus haltreq on one hart
  task automatic halt_hart(input int unsigned hart);
    logic [NR_HARTS-1:0]   exp_req;
    logic [APB_DATA_W-1:0] exp_status;
    exp_req    = '0;
    exp_status = 32'h0000_0002;
    if (hart < NR_HARTS && SELECTABLE_HARTS[hart]) begin
      exp_req[hart] = 1'b1;
    end else begin
      exp_status[12] = 1'b1;
    end
    write_ok(ADDR_DMCONTROL, 32'h8000_0001 | (hart << 16));
    next_cycle();
    check_harts(debug_req_o, exp_req, $sformatf("debug_req_o for hart %0d", hart));
    read_check(ADDR_DMSTATUS, exp_status);
  endtask

  task automatic test_halt_request();
    int unsigned errs;
    errs = err_cnt;
    halt_hart(1);
    halt_hart(700);
    halt_hart(0);
    halt_hart(2);
    // drop haltreq, hart 2 still selected
    write_ok(ADDR_DMCONTROL, 32'h0002_0001);
    next_cycle();
    check_harts(debug_req_o, '0, "debug_req_o after haltreq clear");
    end_test("halt request", errs);
  endtask

  task automatic test_ndm_reset();
    int unsigned errs;
    errs = err_cnt;
    write_ok(ADDR_DMCONTROL, 32'h0000_0003);
    wait_rstn(1'b0, 4);
    check_cause(rst_cause_o, RST_NDM, "rst_cause_o during ndmreset");
    // debug side sits on the global reset only
    check_bit(dmactive_o, 1'b1, "dmactive_o during ndmreset");
    read_check(ADDR_DMCONTROL, 32'h0000_0003);
    write_ok(ADDR_DMCONTROL, 32'h0000_0001);
    wait_rstn(1'b1, RST_HOLD + 10);
    check_cause(rst_cause_o, RST_NDM, "rst_cause_o after ndmreset");
    read_check(ADDR_DATA0, data0_val);
    read_check(ADDR_DMCONTROL, 32'h0000_0001);
    end_test("non-debug reset", errs);
  endtask

  // enabled watchdog with optional kick period, reset must stay off
  task automatic run_quiet(input int unsigned cycles, input int unsigned kick_period,
                           input string what);
    int unsigned i;
    logic        rst_seen;
    rst_seen = 1'b0;
    for (i = 1; i <= cycles; i++) begin
      next_cycle();
      wdog_kick_i = (kick_period != 0) && (i % kick_period == 0);
      if (periph_rstn_o !== 1'b1) begin
        rst_seen = 1'b1;
      end
    end
    wdog_kick_i = 1'b0;
    check_bit(rst_seen, 1'b0, what);
  endtask

  task automatic test_watchdog();
    int unsigned errs;
    errs = err_cnt;
    write_ok(ADDR_DMCONTROL, 32'h0000_0000);
    wdog_en_i = 1'b1;
    wait_rstn(1'b0, WDOG_TIMEOUT + 10);
    check_cause(rst_cause_o, RST_WDOG, "rst_cause_o after expiry");
    wdog_en_i = 1'b0;
    wait_rstn(1'b1, RST_HOLD + 10);
    // debug session freezes the count
    write_ok(ADDR_DMCONTROL, 32'h0000_0001);
    wdog_en_i = 1'b1;
    run_quiet(2 * WDOG_TIMEOUT, 0, "reset seen during debug session");
    wdog_en_i = 1'b0;
    write_ok(ADDR_DMCONTROL, 32'h0000_0000);
    wdog_en_i = 1'b1;
    run_quiet(2 * WDOG_TIMEOUT, 50, "reset seen with regular kicks");
    wdog_en_i = 1'b0;
    end_test("watchdog", errs);
  endtask

`endif

// File: dv/tb_soc_dbg.sv
// debug slice testbench
`timescale 1ns/1ps

module tb_soc_dbg;

  import soc_dbg_pkg::*;

  // dut side, named after the top level ports
  logic                  s_soc_clk;
  logic                  s_soc_rstn;
  logic                  psel_i;
  logic                  penable_i;
  logic                  pwrite_i;
  logic [APB_ADDR_W-1:0] paddr_i;
  logic [APB_DATA_W-1:0] pwdata_i;
  logic [APB_DATA_W-1:0] prdata_o;
  logic                  pready_o;
  logic                  pslverr_o;
  logic                  wdog_en_i;
  logic                  wdog_kick_i;
  logic                  periph_rstn_o;
  logic [NR_HARTS-1:0]   debug_req_o;
  logic                  dmactive_o;
  rst_cause_e            rst_cause_o;

  // run bookkeeping
  int unsigned           err_cnt;
  int unsigned           test_cnt;
  // DATA0 word written early, checked again after ndmreset
  logic [APB_DATA_W-1:0] data0_val;

  // 40 ns period
  initial s_soc_clk = 1'b0;
  always #20 s_soc_clk = ~s_soc_clk;

  soc_dbg_top UUT (.*);

  // ******************************
  // run control
  // ******************************

  // one clock, then the drive offset
  task automatic next_cycle();
    @(posedge s_soc_clk);
    #2;
  endtask

  // a wait ran out, so the run ends here
  task automatic abort_run(input string what);
    $display("ERROR at %0t: %s", $time, what);
    $display("STATUS: FAIL");
    $finish;
  endtask

  // one summary line per test
  task automatic end_test(input string name, input int unsigned errs_before);
    test_cnt++;
    $display("test %s: %0d errors", name, err_cnt - errs_before);
  endtask

  `include "tb_soc_dbg_tasks.svh"

  initial begin
    void'($urandom(32'h65a0));
    err_cnt    = 0;
    test_cnt   = 0;
    data0_val  = '0;
    s_soc_rstn = 1'b0;
    paddr_i    = '0;
    pwdata_i   = '0;
    {psel_i, penable_i, pwrite_i, wdog_en_i, wdog_kick_i} = '0;
    // global reset over 16 clocks
    repeat (16) @(posedge s_soc_clk);
    #2;
    s_soc_rstn = 1'b1;

    test_reset_values();
    test_scratch_errors();
    test_halt_request();
    test_ndm_reset();
    test_watchdog();

    $display("tests %0d, errors %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: logic/dbg_regs.sv
// debug module register block
`timescale 1ns/1ps

module dbg_regs (
  input  logic                               s_soc_clk,
  input  logic                               s_soc_rstn,
  // apb slave port
  input  logic                               psel_i,
  input  logic                               penable_i,
  input  logic                               pwrite_i,
  input  logic [soc_dbg_pkg::APB_ADDR_W-1:0] paddr_i,
  input  logic [soc_dbg_pkg::APB_DATA_W-1:0] pwdata_i,
  output logic [soc_dbg_pkg::APB_DATA_W-1:0] prdata_o,
  output logic                               pready_o,
  output logic                               pslverr_o,
  // debug session outputs
  output logic                               dmactive_o,
  output logic                               ndmreset_o,
  output logic [soc_dbg_pkg::NR_HARTS-1:0]   debug_req_o
);

  import soc_dbg_pkg::*;

  // bridge side
  logic                    req;
  logic                    req_we;
  logic                    req_err;
  logic                    r_valid;
  logic                    slverr_q;
  logic [APB_DATA_W-1:0]   rdata_q;
  logic [APB_ADDR_W-3:0]   word_addr;
  logic                    addr_hit;
  logic                    ro_reg;
  logic [APB_DATA_W-1:0]   rdata_d;

  // register contents
  logic [APB_DATA_W-1:0]   data0;
  logic [APB_DATA_W-1:0]   data1;
  logic                    active;
  logic                    ndmreset;
  logic                    haltreq;
  logic [HARTSEL_W-1:0]    hartsel;

  // assembled words and hart selection
  logic [APB_DATA_W-1:0]   dmcontrol_word;
  logic [APB_DATA_W-1:0]   dmstatus_word;
  logic [NR_HARTS-1:0]     hart_sel_oh;
  logic                    hart_avail;
  logic [NR_HARTS-1:0]     debug_req_q;

  // ******************************
  // apb to register request
  // ******************************

  // one request in the first access cycle, granted at once
  // the registered valid then drives pready in the second cycle
  assign req       = psel_i & penable_i & ~r_valid;
  assign word_addr = paddr_i[APB_ADDR_W-1:2];

  always_comb begin
    addr_hit = 1'b1;
    ro_reg   = 1'b0;
    rdata_d  = '0;
    case (word_addr)
      ADDR_DATA0:     rdata_d = data0;
      ADDR_DATA1:     rdata_d = data1;
      ADDR_DMCONTROL: rdata_d = dmcontrol_word;
      ADDR_DMSTATUS: begin
        rdata_d = dmstatus_word;
        ro_reg  = 1'b1;
      end
      ADDR_HARTINFO: begin
        rdata_d = HARTINFO_VALUE;
        ro_reg  = 1'b1;
      end
      default:        addr_hit = 1'b0;
    endcase
  end

  // unmapped, misaligned or write to a read-only word
  assign req_err = ~addr_hit | (paddr_i[1:0] != 2'b00) | (pwrite_i & ro_reg);
  assign req_we  = req & pwrite_i & ~req_err;

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      r_valid  <= 1'b0;
      slverr_q <= 1'b0;
    end else begin
      r_valid  <= req;
      slverr_q <= req & req_err;
    end
  end

  // read data captured with the grant
  always_ff @(posedge s_soc_clk) begin
    if (req) begin
      rdata_q <= rdata_d;
    end
  end

  assign pready_o  = r_valid;
  assign pslverr_o = slverr_q;
  assign prdata_o  = rdata_q;

  // ******************************
  // register file
  // ******************************

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      data0    <= '0;
      data1    <= '0;
      active   <= 1'b0;
      ndmreset <= 1'b0;
      haltreq  <= 1'b0;
      hartsel  <= '0;
    end else if (req_we) begin
      case (word_addr)
        ADDR_DATA0: data0 <= pwdata_i;
        ADDR_DATA1: data1 <= pwdata_i;
        ADDR_DMCONTROL: begin
          active   <= pwdata_i[DMCTRL_ACTIVE_BIT];
          ndmreset <= pwdata_i[DMCTRL_NDMRESET_BIT];
          haltreq  <= pwdata_i[DMCTRL_HALTREQ_BIT];
          hartsel  <= pwdata_i[DMCTRL_HARTSEL_LSB +: HARTSEL_W];
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    dmcontrol_word                                   = '0;
    dmcontrol_word[DMCTRL_ACTIVE_BIT]                = active;
    dmcontrol_word[DMCTRL_NDMRESET_BIT]              = ndmreset;
    dmcontrol_word[DMCTRL_HALTREQ_BIT]               = haltreq;
    dmcontrol_word[DMCTRL_HARTSEL_LSB +: HARTSEL_W]  = hartsel;
  end

  // ******************************
  // hart selection
  // ******************************

  // decode the full 10 bit select, larger values hit no hart
  always_comb begin
    for (int h = 0; h < NR_HARTS; h++) begin
      hart_sel_oh[h] = (hartsel == HARTSEL_W'(h));
    end
  end

  assign hart_avail = |(hart_sel_oh & SELECTABLE_HARTS);

  always_comb begin
    dmstatus_word                       = '0;
    dmstatus_word[3:0]                  = DMSTATUS_VERSION;
    dmstatus_word[DMSTATUS_UNAVAIL_BIT] = ~hart_avail;
  end

  // request follows the control word one cycle later
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      debug_req_q <= '0;
    end else if (active && haltreq) begin
      debug_req_q <= hart_sel_oh & SELECTABLE_HARTS;
    end else begin
      debug_req_q <= '0;
    end
  end

  assign debug_req_o = debug_req_q;
  assign dmactive_o  = active;
  assign ndmreset_o  = ndmreset;

  // pready may only answer a transfer still in its access phase
  a_pready_in_access: assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    pready_o |-> (psel_i && penable_i));

  // no request ever reaches a hart outside the selectable set
  a_req_selectable: assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    (debug_req_o & ~SELECTABLE_HARTS) == '0);

endmodule

// File: logic/rst_ctrl.sv
// peripheral reset controller
`timescale 1ns/1ps

module rst_ctrl (
  input  logic                    s_soc_clk,
  // global reset, async active low
  input  logic                    s_soc_rstn,
  // watchdog strobe and debug module reset level
  input  logic                    wd_expired_i,
  input  logic                    ndmreset_i,
  output logic                    periph_rstn_o,
  output soc_dbg_pkg::rst_cause_e rst_cause_o
);

  import soc_dbg_pkg::*;

  logic                  rst_req;
  logic [RST_HOLD_W-1:0] hold_cnt_q;
  logic                  periph_rstn_q;
  rst_cause_e            rst_cause_q;

  // ******************************
  // reset stretch
  // ******************************

  // any synchronous source pulls the peripheral domain down
  assign rst_req = wd_expired_i | ndmreset_i;

  // global reset drops the output at once, release is always
  // clocked and follows the last cause by RST_HOLD cycles
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      hold_cnt_q    <= RST_HOLD;
      periph_rstn_q <= 1'b0;
    end else if (rst_req) begin
      // reload while a cause is present
      hold_cnt_q    <= RST_HOLD;
      periph_rstn_q <= 1'b0;
    end else begin
      if (hold_cnt_q != '0) begin
        hold_cnt_q <= hold_cnt_q - 1'b1;
      end
      // release on the edge that drains the counter
      periph_rstn_q <= (hold_cnt_q <= RST_HOLD_W'(1));
    end
  end

  assign periph_rstn_o = periph_rstn_q;

  // ******************************
  // reset cause record
  // ******************************

  // power-on cause after global reset, then the latest source wins
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      rst_cause_q <= RST_POWER;
    end else if (wd_expired_i) begin
      rst_cause_q <= RST_WDOG;
    end else if (ndmreset_i) begin
      rst_cause_q <= RST_NDM;
    end
  end

  assign rst_cause_o = rst_cause_q;

  // a non-debug reset request always lands in the peripheral domain
  a_ndm_holds_reset: assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    ndmreset_i |=> !periph_rstn_o);

endmodule

// File: logic/soc_dbg_pkg.sv
// soc debug and reset definitions

package soc_dbg_pkg;

  // ******************************
  // apb debug port
  // ******************************

  // byte address width, word address sits in bits 8..2
  localparam int unsigned APB_ADDR_W = 9;
  localparam int unsigned APB_DATA_W = 32;

  // ******************************
  // hart set
  // ******************************

  // harts wired to the debug request vector
  localparam int unsigned NR_HARTS = 4;

  // one bit per hart that exists and may be selected
  // only harts 0 and 2 are populated
  localparam logic [NR_HARTS-1:0] SELECTABLE_HARTS = 4'b0101;

  // hart select field of the control word, bits 25..16
  localparam int unsigned HARTSEL_W = 10;
  localparam int unsigned DMCTRL_HARTSEL_LSB = 16;

  // ******************************
  // register map
  // ******************************

  // word addresses, compared against paddr[8:2]
  localparam logic [6:0] ADDR_DATA0     = 7'h04;
  localparam logic [6:0] ADDR_DATA1     = 7'h05;
  localparam logic [6:0] ADDR_DMCONTROL = 7'h10;
  localparam logic [6:0] ADDR_DMSTATUS  = 7'h11;
  localparam logic [6:0] ADDR_HARTINFO  = 7'h12;

  // control word fields
  localparam int unsigned DMCTRL_ACTIVE_BIT   = 0;
  localparam int unsigned DMCTRL_NDMRESET_BIT = 1;
  localparam int unsigned DMCTRL_HALTREQ_BIT  = 31;

  // status word fields
  // set when the selected hart is out of range or not selectable
  localparam int unsigned DMSTATUS_UNAVAIL_BIT = 12;
  // debug spec version field, bits 3..0
  localparam logic [3:0] DMSTATUS_VERSION = 4'd2;

  // hart information word
  // nscratch = 2 in bits 23..20, dataaccess in bit 16,
  // datasize = 2 in bits 15..12, dataaddr = 12'h380 in bits 11..0
  localparam logic [APB_DATA_W-1:0] HARTINFO_VALUE = 32'h0021_2380;

  // ******************************
  // watchdog and reset timing
  // ******************************

  // enabled and unpaused cycles until the watchdog fires
  localparam int unsigned WDOG_CNT_W = 8;
  localparam logic [WDOG_CNT_W-1:0] WDOG_TIMEOUT = 8'd200;

  // cycles the peripheral reset stays low after its last cause
  localparam int unsigned RST_HOLD_W = 4;
  localparam logic [RST_HOLD_W-1:0] RST_HOLD = 4'd8;

  // source of the most recent peripheral reset
  typedef enum logic [1:0] {
    RST_POWER = 2'd0,
    RST_WDOG  = 2'd1,
    RST_NDM   = 2'd2
  } rst_cause_e;

endpackage

// File: logic/soc_dbg_top.sv
// soc debug and reset slice
`timescale 1ns/1ps

module soc_dbg_top (
  input  logic                               s_soc_clk,
  // global reset
  input  logic                               s_soc_rstn,
  // apb debug port
  input  logic                               psel_i,
  input  logic                               penable_i,
  input  logic                               pwrite_i,
  input  logic [soc_dbg_pkg::APB_ADDR_W-1:0] paddr_i,
  input  logic [soc_dbg_pkg::APB_DATA_W-1:0] pwdata_i,
  output logic [soc_dbg_pkg::APB_DATA_W-1:0] prdata_o,
  output logic                               pready_o,
  output logic                               pslverr_o,
  // watchdog control
  input  logic                               wdog_en_i,
  input  logic                               wdog_kick_i,
  // domain status
  output logic                               periph_rstn_o,
  output logic [soc_dbg_pkg::NR_HARTS-1:0]   debug_req_o,
  output logic                               dmactive_o,
  output soc_dbg_pkg::rst_cause_e            rst_cause_o
);

  logic s_dmactive;
  logic s_ndmreset;
  logic s_wd_expired;
  logic s_periph_rstn;

  // ******************************
  // debug registers
  // ******************************

  // global reset only, so a session outlives ndmreset
  dbg_regs i_dbg_regs (
    .s_soc_clk   (s_soc_clk),
    .s_soc_rstn  (s_soc_rstn),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .dmactive_o  (s_dmactive),
    .ndmreset_o  (s_ndmreset),
    .debug_req_o (debug_req_o)
  );

  // watchdog lives in the peripheral reset domain
  soc_watchdog i_soc_watchdog (
    .s_soc_clk     (s_soc_clk),
    .periph_rstn_i (s_periph_rstn),
    .wdog_en_i     (wdog_en_i),
    .wdog_kick_i   (wdog_kick_i),
    .dmactive_i    (s_dmactive),
    .wd_expired_o  (s_wd_expired)
  );

  // merge global, watchdog and debug resets
  rst_ctrl i_rst_ctrl (
    .s_soc_clk     (s_soc_clk),
    .s_soc_rstn    (s_soc_rstn),
    .wd_expired_i  (s_wd_expired),
    .ndmreset_i    (s_ndmreset),
    .periph_rstn_o (s_periph_rstn),
    .rst_cause_o   (rst_cause_o)
  );

  assign periph_rstn_o = s_periph_rstn;
  assign dmactive_o    = s_dmactive;

endmodule

// File: logic/soc_watchdog.sv
// peripheral domain watchdog
`timescale 1ns/1ps

module soc_watchdog (
  input  logic s_soc_clk,
  // peripheral reset, async active low
  input  logic periph_rstn_i,
  input  logic wdog_en_i,
  input  logic wdog_kick_i,
  // debug session freezes the count
  input  logic dmactive_i,
  output logic wd_expired_o
);

  import soc_dbg_pkg::*;

  logic [WDOG_CNT_W-1:0] cnt_q;
  logic                  cnt_en;
  logic                  cnt_last;
  logic                  expired_q;

  // ******************************
  // timeout counter
  // ******************************

  // counting only while enabled and no debugger attached
  assign cnt_en   = wdog_en_i & ~dmactive_i;
  assign cnt_last = (cnt_q == WDOG_CNT_W'(WDOG_TIMEOUT - 1));

  always_ff @(posedge s_soc_clk or negedge periph_rstn_i) begin
    if (!periph_rstn_i) begin
      cnt_q     <= '0;
      expired_q <= 1'b0;
    end else begin
      // expiry flag is a single cycle strobe
      expired_q <= 1'b0;
      if (wdog_kick_i || !wdog_en_i) begin
        // kick or disable restarts the timeout
        cnt_q <= '0;
      end else if (cnt_en) begin
        if (cnt_last) begin
          cnt_q     <= '0;
          expired_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  assign wd_expired_o = expired_q;

  // the strobe never stretches over two cycles
  a_expired_pulse: assert property (@(posedge s_soc_clk) disable iff (!periph_rstn_i)
    wd_expired_o |=> !wd_expired_o);

endmodule

// File: tb.f
+incdir+dv
logic/soc_dbg_pkg.sv
logic/dbg_regs.sv
logic/soc_watchdog.sv
logic/rst_ctrl.sv
logic/soc_dbg_top.sv
dv/tb_soc_dbg.sv
